// ==== Makefile ====
SIM   ?= verilator
FLAGS ?= --binary --timing -j 0
TOP   ?= tb_mbus_top
FLIST ?= flist.f
BUILD ?= obj_dir
LOG   ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with $(SIM), run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then \
		echo "simulation reported a failure"; \
		exit 1; \
	fi
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== bus_test_master.sv ====
`timescale 1ns/10ps
`include "mbus_settings.svh"

module bus_test_master import mbus_pkg::*, master_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       en,
    input  logic       write,
    input  mbus_addr_t addr,
    input  mbus_data_t wdata,
    input  beat_t      rdata_sel,
    output logic       busy,
    output logic       done,
    output mbus_data_t rdata,
    mbus_if.master     bus
);

    localparam beat_t       LAST_BEAT  = beat_t'(`MBUS_BURST_LEN - 1);
    localparam mbus_burst_t BURST_CODE = mbus_burst_t'(`MBUS_BURST_LEN - 1);

    master_state_e state;
    master_state_e next_state;
    beat_t         beat;
    logic          we_q;
    mbus_addr_t    addr_q;
    mbus_data_t    wdata_q;
    mbus_data_t    rf [4];  // captured read beats
    logic          wait_in;

    assign wait_in = bus.ctrl_in[CTRL_WAIT_BIT];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= m_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            m_idle: begin
                if (en) begin
                    next_state = m_req;
                end
            end
            m_req: begin
                if (bus.ack) begin
                    next_state = m_present_addr;
                end
            end
            m_present_addr: next_state = m_slave_wait;  // one address cycle only
            m_slave_wait: begin
                if (!wait_in) begin
                    next_state = we_q ? m_write_data : m_read_data;
                end
            end
            m_write_data, m_read_data: begin
                if (beat == LAST_BEAT) begin
                    next_state = m_finish;
                end
            end
            m_finish: next_state = m_idle;
            default:  next_state = m_idle;
        endcase
    end

    // command taken only from idle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            we_q <= 1'b0;
        end else if (state == m_idle && en) begin
            we_q <= write;
        end
    end

    always_ff @(posedge clk) begin
        if (state == m_idle && en) begin
            addr_q  <= addr;
            wdata_q <= wdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat <= '0;
        end else if (state == m_write_data || state == m_read_data) begin
            beat <= beat + 1'b1;
        end else begin
            beat <= '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++) begin
                rf[i] <= '0;
            end
        end else if (state == m_read_data) begin
            rf[beat] <= bus.bus_in;
        end
    end

    assign rdata = rf[rdata_sel];

    assign bus.req = state inside {m_req, m_present_addr, m_slave_wait,
                                   m_write_data, m_read_data};
    assign bus.addr_valid = (state == m_present_addr);
    assign bus.ctrl_out   = {3'b000, BURST_CODE, we_q, 1'b0};

    always_comb begin
        if (state == m_write_data) begin
            bus.bus_out = wdata_q + mbus_data_t'(beat);  // base plus beat
        end else begin
            bus.bus_out = mbus_data_t'(addr_q);
        end
    end

    assign busy = (state != m_idle);
    assign done = (state == m_finish);

    // once granted, req and ack stay up together until the burst is done
    a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        (bus.req && bus.ack) |=> ((bus.req && bus.ack) || done))
        else $error("req or ack dropped before the burst ended");

endmodule

// ==== flist.f ====
+incdir+.
mbus_pkg.sv
master_pkg.sv
mbus_if.sv
mbus_arbiter.sv
bus_test_master.sv
mbus_mem_slave.sv
mbus_top.sv
mbus_checker.sv
tb_mbus_top.sv

// ==== master_pkg.sv ====
package master_pkg;

    // states in the order a transfer walks through them
    typedef enum logic [2:0] {
        m_idle         = 3'd0,
        m_req          = 3'd1,
        m_present_addr = 3'd2,
        m_slave_wait   = 3'd3,
        m_write_data   = 3'd4,
        m_read_data    = 3'd5,
        m_finish       = 3'd6
    } master_state_e;

    typedef logic [1:0] beat_t;       // beat in a burst and read file index
    typedef logic [0:0] master_id_t;  // which master owns the bus

endpackage

// ==== mbus_arbiter.sv ====
`timescale 1ns/10ps

module mbus_arbiter import mbus_pkg::*, master_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    mbus_if.arbiter   m0,
    mbus_if.arbiter   m1,
    mbus_if.slave_side s
);

    // what a master sees without the bus
    localparam mbus_ctrl_t IDLE_CTRL = mbus_ctrl_t'(1 << CTRL_WAIT_BIT);

    logic [1:0] req;
    logic [1:0] grant_q;  // one-hot, bit per master
    logic [1:0] grant_d;
    master_id_t last_id;

    assign req = {m1.req, m0.req};

    always_comb begin
        grant_d = grant_q;
        if ((grant_q & req) == 2'b00) begin  // free, or owner let go
            case (req)
                2'b01:   grant_d = 2'b01;
                2'b10:   grant_d = 2'b10;
                2'b11:   grant_d = (last_id == 1'b0) ? 2'b10 : 2'b01;
                default: grant_d = 2'b00;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grant_q <= 2'b00;
            last_id <= '0;
        end else begin
            grant_q <= grant_d;
            if (grant_d != 2'b00 && grant_d != grant_q) begin
                last_id <= master_id_t'(grant_d[1]);
            end
        end
    end

    assign m0.ack = grant_q[0];
    assign m1.ack = grant_q[1];

    always_comb begin
        s.bus_out    = '0;
        s.ctrl_out   = '0;
        s.addr_valid = 1'b0;
        m0.bus_in    = '0;
        m1.bus_in    = '0;
        m0.ctrl_in   = IDLE_CTRL;
        m1.ctrl_in   = IDLE_CTRL;
        if (grant_q[0]) begin
            s.bus_out    = m0.bus_out;
            s.ctrl_out   = m0.ctrl_out;
            s.addr_valid = m0.addr_valid;
            m0.bus_in    = s.bus_in;
            m0.ctrl_in   = s.ctrl_in;
        end else if (grant_q[1]) begin
            s.bus_out    = m1.bus_out;
            s.ctrl_out   = m1.ctrl_out;
            s.addr_valid = m1.addr_valid;
            m1.bus_in    = s.bus_in;
            m1.ctrl_in   = s.ctrl_in;
        end
    end

    a_single_ack: assert property (@(posedge clk) disable iff (!rst_n)
        !(m0.ack && m1.ack))
        else $error("ack high to both masters");

endmodule

// ==== mbus_checker.sv ====
`timescale 1ns/10ps

module mbus_checker import mbus_pkg::*, master_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       busy0,
    input  logic       busy1,
    input  logic       done0,
    input  logic       done1,
    input  mbus_data_t rdata0,
    input  mbus_data_t rdata1,
    input  beat_t      rdata_sel0,
    input  beat_t      rdata_sel1,
    input  logic       chk_idle,    // expect quiet outputs this cycle
    input  logic       chk_rd0,
    input  logic       chk_rd1,
    input  mbus_data_t exp_rd0,
    input  mbus_data_t exp_rd1,
    input  int         test_num,
    input  logic       test_end,
    output int         check_count,
    output int         error_count
);

    int         test_checks;
    int         test_errors;
    logic [1:0] done_q;

    function automatic string test_name(input int n);
        case (n)
            1:       return "reset state";
            2:       return "write then read";
            3:       return "address wrap";
            4:       return "both masters at once";
            5:       return "random mixed commands";
            default: return "unnamed";
        endcase
    endfunction

    task automatic compare(input string what, input mbus_data_t got, input mbus_data_t exp);
        check_count = check_count + 1;
        test_checks = test_checks + 1;
        if (got !== exp) begin
            error_count = error_count + 1;
            test_errors = test_errors + 1;
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            check_count = 0;
            error_count = 0;
            test_checks = 0;
            test_errors = 0;
            done_q      = 2'b00;
        end else begin
            if (chk_idle) begin
                compare("master 0 busy and done", mbus_data_t'({busy0, done0}), '0);
                compare("master 1 busy and done", mbus_data_t'({busy1, done1}), '0);
                compare("master 0 rdata", rdata0, '0);
                compare("master 1 rdata", rdata1, '0);
            end
            if (chk_rd0) begin
                compare($sformatf("master 0 read beat %0d", rdata_sel0), rdata0, exp_rd0);
            end
            if (chk_rd1) begin
                compare($sformatf("master 1 read beat %0d", rdata_sel1), rdata1, exp_rd1);
            end
            // done is a single pulse and the master is idle right after
            if (done_q[0]) begin
                compare("master 0 busy and done after done", mbus_data_t'({busy0, done0}), '0);
            end
            if (done_q[1]) begin
                compare("master 1 busy and done after done", mbus_data_t'({busy1, done1}), '0);
            end
            done_q = {done1, done0};
            if (test_end) begin
                $display("test %0d %s: %0d checks, %0d errors", test_num,
                         test_name(test_num), test_checks, test_errors);
                test_checks = 0;
                test_errors = 0;
            end
        end
    end

endmodule

// ==== mbus_if.sv ====
`timescale 1ns/10ps

interface mbus_if import mbus_pkg::*; ();

    // names are seen from the master side
    logic       req;
    logic       ack;
    mbus_data_t bus_out;     // address or write data toward the slave
    mbus_data_t bus_in;      // read data back from the slave
    mbus_ctrl_t ctrl_out;    // burst code and we toward the slave
    mbus_ctrl_t ctrl_in;     // wait back from the slave
    logic       addr_valid;  // bus_out holds the address this cycle

    modport master (
        output req, bus_out, ctrl_out, addr_valid,
        input  ack, bus_in, ctrl_in
    );

    // arbiter facing one master
    modport arbiter (
        input  req, bus_out, ctrl_out, addr_valid,
        output ack, bus_in, ctrl_in
    );

    // arbiter facing the slave
    modport slave_side (
        output bus_out, ctrl_out, addr_valid,
        input  bus_in, ctrl_in
    );

    modport slave (
        input  bus_out, ctrl_out, addr_valid,
        output bus_in, ctrl_in
    );

endinterface

// ==== mbus_mem_slave.sv ====
`timescale 1ns/10ps
`include "mbus_settings.svh"

module mbus_mem_slave import mbus_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    mbus_if.slave bus
);

    localparam int         WAIT_CYCLES = `MBUS_SLAVE_WAIT;
    localparam logic [3:0] WAIT_LAST   = (WAIT_CYCLES > 1) ? 4'(WAIT_CYCLES - 2) : 4'd0;

    slave_state_e state;
    logic         we_q;
    mbus_burst_t  burst_q;
    mbus_burst_t  beat;
    logic [3:0]   wait_cnt;
    mbus_addr_t   base_q;
    mbus_addr_t   mem_idx;
    logic         wait_out;
    mbus_data_t   mem [`MBUS_MEM_DEPTH];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= s_idle;
            we_q     <= 1'b0;
            burst_q  <= '0;
            beat     <= '0;
            wait_cnt <= '0;
        end else begin
            case (state)
                s_idle: begin
                    if (bus.addr_valid) begin
                        we_q     <= bus.ctrl_out[CTRL_WE_BIT];
                        burst_q  <= bus.ctrl_out[CTRL_BURST_MSB:CTRL_BURST_LSB];
                        wait_cnt <= '0;
                        if (WAIT_CYCLES > 1) begin
                            state <= s_wait;
                        end else begin
                            state <= s_addr;
                        end
                    end
                end
                s_wait: begin
                    wait_cnt <= wait_cnt + 1'b1;
                    if (wait_cnt == WAIT_LAST) begin
                        state <= s_addr;
                    end
                end
                s_addr: begin
                    beat  <= '0;
                    state <= s_data;
                end
                s_data: begin
                    beat <= beat + 1'b1;
                    if (beat == burst_q) begin
                        state <= s_idle;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == s_idle && bus.addr_valid) begin
            base_q <= bus.bus_out[`MBUS_ADDR_W-1:0];
        end
    end

    assign mem_idx = base_q + mbus_addr_t'(beat);  // wraps past the top word

    always_ff @(posedge clk) begin
        if (state == s_data && we_q) begin
            mem[mem_idx] <= bus.bus_out;
        end
    end

    assign bus.bus_in = (state == s_data && !we_q) ? mem[mem_idx] : '0;

    // high through the address cycle and the wait count
    assign wait_out = (state == s_idle) || (state == s_wait);

    always_comb begin
        bus.ctrl_in                = '0;
        bus.ctrl_in[CTRL_WAIT_BIT] = wait_out;
    end

    a_no_addr_in_data: assert property (@(posedge clk) disable iff (!rst_n)
        (state == s_data) |-> !bus.addr_valid)
        else $error("address strobe during a data burst");

endmodule

// ==== mbus_pkg.sv ====
`include "mbus_settings.svh"

package mbus_pkg;

    typedef logic [`MBUS_ADDR_W-1:0] mbus_addr_t;  // memory word address
    typedef logic [`MBUS_DATA_W-1:0] mbus_data_t;  // bus word

    // control field {unused[2:0], burst[2:0], we, wait}
    typedef logic [7:0] mbus_ctrl_t;
    typedef logic [2:0] mbus_burst_t;  // beats minus one

    localparam int CTRL_WAIT_BIT  = 0;
    localparam int CTRL_WE_BIT    = 1;
    localparam int CTRL_BURST_LSB = 2;
    localparam int CTRL_BURST_MSB = 4;

    typedef enum logic [1:0] {
        s_idle = 2'd0,
        s_addr = 2'd1,  // wait dropped, data follows next cycle
        s_wait = 2'd2,
        s_data = 2'd3
    } slave_state_e;

endpackage

// ==== mbus_settings.svh ====
`ifndef MBUS_SETTINGS_SVH
`define MBUS_SETTINGS_SVH

// bus widths
`define MBUS_ADDR_W      8
`define MBUS_DATA_W      32

// beats per transfer, 1 to 4
`define MBUS_BURST_LEN   4

// cycles wait stays high counted from the address cycle, 1 or more
`define MBUS_SLAVE_WAIT  2

// memory words, equal to 2**MBUS_ADDR_W so the word address wraps by itself
`define MBUS_MEM_DEPTH   256

`endif

// ==== mbus_top.sv ====
`timescale 1ns/10ps

module mbus_top import mbus_pkg::*, master_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       en0,
    input  logic       en1,
    input  logic       write0,
    input  logic       write1,
    input  mbus_addr_t addr0,
    input  mbus_addr_t addr1,
    input  mbus_data_t wdata0,
    input  mbus_data_t wdata1,
    input  beat_t      rdata_sel0,
    input  beat_t      rdata_sel1,
    output logic       busy0,
    output logic       busy1,
    output logic       done0,
    output logic       done1,
    output mbus_data_t rdata0,
    output mbus_data_t rdata1
);

    mbus_if m0_bus ();
    mbus_if m1_bus ();
    mbus_if s_bus ();  // shared side, after the mux

    bus_test_master master0_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (en0),
        .write     (write0),
        .addr      (addr0),
        .wdata     (wdata0),
        .rdata_sel (rdata_sel0),
        .busy      (busy0),
        .done      (done0),
        .rdata     (rdata0),
        .bus       (m0_bus.master)
    );

    bus_test_master master1_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (en1),
        .write     (write1),
        .addr      (addr1),
        .wdata     (wdata1),
        .rdata_sel (rdata_sel1),
        .busy      (busy1),
        .done      (done1),
        .rdata     (rdata1),
        .bus       (m1_bus.master)
    );

    mbus_arbiter arbiter_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .m0    (m0_bus.arbiter),
        .m1    (m1_bus.arbiter),
        .s     (s_bus.slave_side)
    );

    mbus_mem_slave slave_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (s_bus.slave)
    );

endmodule

// ==== tb_mbus_top.sv ====
`timescale 1ns/10ps
`include "mbus_settings.svh"

module tb_mbus_top import mbus_pkg::*, master_pkg::*; ();

    localparam int BL         = `MBUS_BURST_LEN;
    localparam int MIN_LAT    = 4 + `MBUS_SLAVE_WAIT + `MBUS_BURST_LEN;
    localparam int OP_CYCLES  = 2 * (2 * MIN_LAT + BL + 2);  // other master first, then readback
    localparam int RAND_OPS   = 200;
    localparam int NUM_OPS    = 2 + 3 + 4 + RAND_OPS;
    localparam int MAX_CYCLES = NUM_OPS * OP_CYCLES + 20;

    logic       clk;
    logic       rst_n;
    logic       en [2];
    logic       write [2];
    mbus_addr_t addr [2];
    mbus_data_t wdata [2];
    beat_t      rdata_sel [2];
    logic       busy [2];
    logic       done [2];
    mbus_data_t rdata [2];
    logic       chk_idle;
    logic       chk_rd [2];
    mbus_data_t exp_rd [2];
    int         test_num;
    logic       test_end;
    int         check_count;
    int         error_count;
    int         cycles = 0;

    mbus_data_t  model_mem [`MBUS_MEM_DEPTH];
    logic        known [`MBUS_MEM_DEPTH];  // word written at least once
    logic [31:0] rng [2];

    mbus_top mbus_top_inst (
        .clk (clk), .rst_n (rst_n),
        .en0 (en[0]), .en1 (en[1]), .write0 (write[0]), .write1 (write[1]),
        .addr0 (addr[0]), .addr1 (addr[1]), .wdata0 (wdata[0]), .wdata1 (wdata[1]),
        .rdata_sel0 (rdata_sel[0]), .rdata_sel1 (rdata_sel[1]),
        .busy0 (busy[0]), .busy1 (busy[1]), .done0 (done[0]), .done1 (done[1]),
        .rdata0 (rdata[0]), .rdata1 (rdata[1])
    );

    mbus_checker checker_inst (
        .clk (clk), .rst_n (rst_n),
        .busy0 (busy[0]), .busy1 (busy[1]), .done0 (done[0]), .done1 (done[1]),
        .rdata0 (rdata[0]), .rdata1 (rdata[1]),
        .rdata_sel0 (rdata_sel[0]), .rdata_sel1 (rdata_sel[1]),
        .chk_idle (chk_idle), .chk_rd0 (chk_rd[0]), .chk_rd1 (chk_rd[1]),
        .exp_rd0 (exp_rd[0]), .exp_rd1 (exp_rd[1]),
        .test_num (test_num), .test_end (test_end),
        .check_count (check_count), .error_count (error_count)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] next_rand(input int m);
        rng[m] = xorshift32(rng[m]);
        return rng[m];
    endfunction

    // base in the master's own half, whole burst stays inside it
    function automatic mbus_addr_t half_addr(input int m, input logic [31:0] r);
        logic [6:0] low;
        low = 7'(r % (129 - BL));
        return {m[0], low};
    endfunction

    task automatic run_cmd(input int m, input logic wr, input mbus_addr_t a,
                           input mbus_data_t d, input logic poke);
        mbus_addr_t ai;
        @(negedge clk);
        en[m]    = 1'b1;
        write[m] = wr;
        addr[m]  = a;
        wdata[m] = d;
        for (int b = 0; b < BL; b++) begin
            ai = a + mbus_addr_t'(b);
            if (wr) begin
                model_mem[ai] = d + mbus_data_t'(b);  // base plus beat
                known[ai]     = 1'b1;
            end
        end
        @(negedge clk);
        en[m] = 1'b0;
        while (done[m] !== 1'b1) begin
            if (poke && busy[m]) begin
                en[m]    = 1'b1;  // stray command, master is busy
                write[m] = ~wr;
                addr[m]  = ~a;
                wdata[m] = ~d;
                poke     = 1'b0;
            end
            @(negedge clk);
            en[m] = 1'b0;
        end
        // read file is complete while done is high
        for (int b = 0; b < BL && !wr; b++) begin
            ai           = a + mbus_addr_t'(b);
            rdata_sel[m] = beat_t'(b);
            chk_rd[m]    = known[ai];
            exp_rd[m]    = model_mem[ai];
            @(negedge clk);
        end
        chk_rd[m] = 1'b0;
    endtask

    task automatic random_cmds(input int m, input int count);
        logic [31:0] r;
        mbus_addr_t  a;
        for (int i = 0; i < count; i++) begin
            r = next_rand(m);
            a = half_addr(m, next_rand(m));
            run_cmd(m, r[0], a, next_rand(m), r[1]);
        end
    endtask

    task automatic end_test(input int n);
        @(negedge clk);
        test_num = n;
        test_end = 1'b1;
        @(negedge clk);
        test_end = 1'b0;
    endtask

    initial begin
        mbus_addr_t a0;
        mbus_addr_t a1;
        mbus_data_t d0;
        mbus_data_t d1;
        rst_n    = 1'b0;
        chk_idle = 1'b0;
        test_num = 0;
        test_end = 1'b0;
        for (int m = 0; m < 2; m++) begin
            en[m]        = 1'b0;
            write[m]     = 1'b0;
            addr[m]      = '0;
            wdata[m]     = '0;
            rdata_sel[m] = '0;
            chk_rd[m]    = 1'b0;
            exp_rd[m]    = '0;
        end
        for (int i = 0; i < `MBUS_MEM_DEPTH; i++) begin
            model_mem[i] = '0;
            known[i]     = 1'b0;
        end
        rng[0] = 32'd28713;
        rng[1] = xorshift32(32'd28713);
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        chk_idle = 1'b1;
        repeat (2) @(negedge clk);
        chk_idle = 1'b0;
        end_test(1);

        a0 = half_addr(0, next_rand(0));
        d0 = next_rand(0);
        run_cmd(0, 1'b1, a0, d0, 1'b0);
        run_cmd(0, 1'b0, a0, '0, 1'b0);
        end_test(2);

        a1 = mbus_addr_t'(`MBUS_MEM_DEPTH - 2);
        run_cmd(1, 1'b1, a1, next_rand(1), 1'b0);
        run_cmd(1, 1'b0, a1, '0, 1'b0);
        run_cmd(0, 1'b0, '0, '0, 1'b0);  // low words written by the wrap
        end_test(3);

        a0 = half_addr(0, next_rand(0));
        a1 = half_addr(1, next_rand(1));
        d0 = next_rand(0);
        d1 = next_rand(1);
        fork
            run_cmd(0, 1'b1, a0, d0, 1'b0);
            run_cmd(1, 1'b1, a1, d1, 1'b0);
        join
        fork
            run_cmd(0, 1'b0, a0, '0, 1'b0);
            run_cmd(1, 1'b0, a1, '0, 1'b0);
        join
        end_test(4);

        fork
            random_cmds(0, RAND_OPS / 2);
            random_cmds(1, RAND_OPS / 2);
        join
        end_test(5);

        $display("summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
